// File: mem_pkg.sv
package mem_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and sizes
	//////////////////////////////////////////////////////////////////////

	localparam int WORD_W = 16;
	localparam int ADDR_W = 16;
	localparam int BYTE_W = 8;

	// Receive queue
	localparam int RXQ_DEPTH = 16;
	localparam int RXQ_AW = 4;

	// UART write wait limit, cycles per wait step
	localparam int TX_TIMEOUT = 64;
	localparam int TX_CNT_W = 6;

	// UART ports in the address map
	localparam logic [ADDR_W-1:0] UART_DATA_ADDR = 16'hBF00;
	localparam logic [ADDR_W-1:0] UART_STAT_ADDR = 16'hBF01;

	//////////////////////////////////////////////////////////////////////
	// Request and response types
	//////////////////////////////////////////////////////////////////////

	typedef enum logic {
		MEM_READ,
		MEM_WRITE
	} mem_op_t;

	typedef enum logic [1:0] {
		TGT_RAM,
		TGT_UART_DATA,
		TGT_UART_STAT
	} mem_target_t;

	typedef struct packed {
		mem_op_t op;
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		mem_req_t req;
		mem_target_t target;
	} mem_dec_t;

	typedef struct packed {
		logic [WORD_W-1:0] rdata;
	} mem_rsp_t;

	// Sequencer states, one bus step each
	typedef enum logic [3:0] {
		IDLE,
		RAM_RD_EN,
		RAM_RD_OE,
		RAM_WR_EN,
		RAM_WR_WE,
		RX_RDN,
		RX_CAP,
		RX_PUSH,
		QUEUE_POP,
		TX_SETUP,
		TX_WRN,
		TX_HOLD,
		TX_TBRE,
		TX_TSRE
	} bus_state_t;

endpackage

// File: mem_req_decode.sv
`timescale 1ns/1ns

module mem_req_decode (
	input logic clk,
	input logic rst,

	// CPU side
	input logic req_valid,
	input mem_pkg::mem_req_t req,

	// Toward the sequencer
	input logic dec_taken,
	output logic dec_valid,
	output mem_pkg::mem_dec_t dec
);

	import mem_pkg::*;

	mem_target_t req_target;

	//////////////////////////////////////////////////////////////////////
	// Address classification
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (req.addr == UART_DATA_ADDR) begin
			req_target = TGT_UART_DATA;
		end else if (req.addr == UART_STAT_ADDR) begin
			req_target = TGT_UART_STAT;
		end else begin
			req_target = TGT_RAM;
		end
	end

	// Held until the sequencer takes it
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			dec_valid <= 1'b0;
		end else if (req_valid) begin
			dec_valid <= 1'b1;
		end else if (dec_taken) begin
			dec_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid) begin
			dec.req <= req;
			dec.target <= req_target;
		end
	end

endmodule

// File: rx_queue.sv
`timescale 1ns/1ns

module rx_queue (
	input logic clk,
	input logic rst,

	input logic push,
	input logic pop,
	input logic [mem_pkg::WORD_W-1:0] wdata,
	output logic [mem_pkg::WORD_W-1:0] rdata,
	output logic empty,
	output logic full
);

	import mem_pkg::*;

	logic [WORD_W-1:0] mem [RXQ_DEPTH];
	logic [RXQ_AW-1:0] front;
	logic [RXQ_AW-1:0] tail;
	logic [RXQ_AW:0] count;
	logic push_ok;
	logic pop_ok;

	assign empty = (count == '0);
	assign full = (count == (RXQ_AW + 1)'(RXQ_DEPTH));

	// Overflow and underflow are dropped here
	assign push_ok = push && !full;
	assign pop_ok = pop && !empty;

	assign rdata = mem[front];

	always_ff @(posedge clk) begin
		if (push_ok) begin
			mem[tail] <= wdata;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			front <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (push_ok) begin
				tail <= tail + 1'b1;
			end
			if (pop_ok) begin
				front <= front + 1'b1;
			end
			case ({push_ok, pop_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: bus_sequencer.sv
`timescale 1ns/1ns

module bus_sequencer (
	input logic clk,
	input logic rst,

	// Decoded request
	input logic dec_valid,
	input mem_pkg::mem_dec_t dec,
	output logic dec_taken,

	// Receive queue
	output logic rxq_push,
	output logic [mem_pkg::WORD_W-1:0] rxq_wdata,
	output logic rxq_pop,
	input logic [mem_pkg::WORD_W-1:0] rxq_rdata,
	input logic rxq_empty,
	input logic rxq_full,

	// Response to the CPU
	output logic rsp_valid,
	output mem_pkg::mem_rsp_t rsp,

	// SRAM
	output logic [mem_pkg::ADDR_W-1:0] ram_addr,
	output logic [mem_pkg::WORD_W-1:0] ram_dout,
	input logic [mem_pkg::WORD_W-1:0] ram_din,
	output logic ram_doe,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we,

	// UART chip
	output logic rdn,
	output logic wrn,
	input logic data_ready,
	input logic tbre,
	input logic tsre
);

	import mem_pkg::*;

	bus_state_t state;
	bus_state_t state_next;
	mem_dec_t cur;
	logic [BYTE_W-1:0] rx_byte;
	logic [TX_CNT_W-1:0] tx_cnt;
	logic tx_timeout;
	logic rx_start;
	logic rsp_fire;
	logic [WORD_W-1:0] rsp_data;
	logic [WORD_W-1:0] stat_word;

	// Chip keeps its byte while the queue is full
	assign rx_start = data_ready && !rxq_full;
	assign tx_timeout = (tx_cnt == TX_CNT_W'(TX_TIMEOUT - 1));
	assign stat_word = {{(WORD_W - 2){1'b0}}, rxq_full, !rxq_empty};

	//////////////////////////////////////////////////////////////////////
	// Next state and response
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		dec_taken = 1'b0;
		rsp_fire = 1'b0;
		rsp_data = '0;
		case (state)
			IDLE: begin
				if (rx_start) begin
					state_next = RX_RDN;
				end else if (dec_valid) begin
					dec_taken = 1'b1;
					case (dec.target)
						TGT_UART_STAT: begin
							rsp_fire = 1'b1;
							rsp_data = stat_word;
						end
						TGT_UART_DATA: begin
							state_next = (dec.req.op == MEM_WRITE) ? TX_SETUP : QUEUE_POP;
						end
						default: begin
							state_next = (dec.req.op == MEM_WRITE) ? RAM_WR_EN : RAM_RD_EN;
						end
					endcase
				end
			end
			RAM_RD_EN: state_next = RAM_RD_OE;
			RAM_RD_OE: begin
				rsp_fire = 1'b1;
				rsp_data = ram_din;
				state_next = IDLE;
			end
			RAM_WR_EN: state_next = RAM_WR_WE;
			RAM_WR_WE: begin
				rsp_fire = 1'b1;
				state_next = IDLE;
			end
			RX_RDN: state_next = RX_CAP;
			RX_CAP: state_next = RX_PUSH;
			RX_PUSH: state_next = IDLE;
			QUEUE_POP: begin
				rsp_fire = 1'b1;
				rsp_data = rxq_empty ? '0 : rxq_rdata;
				state_next = IDLE;
			end
			TX_SETUP: state_next = TX_WRN;
			TX_WRN: state_next = TX_HOLD;
			TX_HOLD: state_next = TX_TBRE;
			TX_TBRE: begin
				if (tbre) begin
					state_next = TX_TSRE;
				end else if (tx_timeout) begin
					state_next = TX_SETUP;
				end
			end
			TX_TSRE: begin
				if (tsre) begin
					rsp_fire = 1'b1;
					state_next = IDLE;
				end else if (tx_timeout) begin
					state_next = TX_SETUP;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= IDLE;
			rsp_valid <= 1'b0;
			tx_cnt <= '0;
		end else begin
			state <= state_next;
			rsp_valid <= rsp_fire;
			// Restarts at each wait step
			if ((state == TX_TBRE || state == TX_TSRE) && state_next == state) begin
				tx_cnt <= tx_cnt + 1'b1;
			end else begin
				tx_cnt <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dec_taken) begin
			cur <= dec;
		end
		if (rsp_fire) begin
			rsp.rdata <= rsp_data;
		end
		if (state == RX_CAP) begin
			rx_byte <= ram_din[BYTE_W-1:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Bus control lines
	//////////////////////////////////////////////////////////////////////

	assign ram_en = !(state inside {RAM_RD_EN, RAM_RD_OE, RAM_WR_EN, RAM_WR_WE});
	assign ram_oe = (state != RAM_RD_OE);
	assign ram_we = (state != RAM_WR_WE);
	assign ram_doe = state inside {RAM_WR_EN, RAM_WR_WE, TX_SETUP, TX_WRN, TX_HOLD};
	assign rdn = !(state inside {RX_RDN, RX_CAP});
	assign wrn = (state != TX_WRN);

	assign ram_addr = cur.req.addr;
	// UART byte on the low lane
	assign ram_dout = (cur.target == TGT_RAM) ? cur.req.wdata :
		{{(WORD_W - BYTE_W){1'b0}}, cur.req.wdata[BYTE_W-1:0]};

	assign rxq_push = (state == RX_PUSH);
	assign rxq_pop = (state == QUEUE_POP);
	assign rxq_wdata = {{(WORD_W - BYTE_W){1'b0}}, rx_byte};

endmodule

// File: mem_uart_top.sv
`timescale 1ns/1ns

module mem_uart_top (
	input logic clk,
	input logic rst,

	// CPU memory stage
	input logic req_valid,
	input mem_pkg::mem_req_t req,
	output logic rsp_valid,
	output mem_pkg::mem_rsp_t rsp,

	// SRAM pins, data pad split
	output logic [mem_pkg::ADDR_W-1:0] ram_addr,
	output logic [mem_pkg::WORD_W-1:0] ram_dout,
	input logic [mem_pkg::WORD_W-1:0] ram_din,
	output logic ram_doe,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we,

	// UART chip pins
	output logic rdn,
	output logic wrn,
	input logic data_ready,
	input logic tbre,
	input logic tsre
);

	import mem_pkg::*;

	logic dec_valid;
	logic dec_taken;
	mem_dec_t dec;
	logic rxq_push;
	logic rxq_pop;
	logic [WORD_W-1:0] rxq_wdata;
	logic [WORD_W-1:0] rxq_rdata;
	logic rxq_empty;
	logic rxq_full;

	mem_req_decode u_decode (.*);

	bus_sequencer u_seq (.*);

	rx_queue u_rxq (
		.clk(clk),
		.rst(rst),
		.push(rxq_push),
		.pop(rxq_pop),
		.wdata(rxq_wdata),
		.rdata(rxq_rdata),
		.empty(rxq_empty),
		.full(rxq_full)
	);

endmodule

// File: tb_dev_models.sv
`timescale 1ns/1ns

module tb_dev_models (
	input logic clk,
	input logic rst,

	// Shared bus from the DUT
	input logic [mem_pkg::ADDR_W-1:0] ram_addr,
	input logic [mem_pkg::WORD_W-1:0] ram_dout,
	output logic [mem_pkg::WORD_W-1:0] ram_din,
	input logic ram_doe,
	input logic ram_en,
	input logic ram_oe,
	input logic ram_we,

	// UART chip
	input logic rdn,
	input logic wrn,
	output logic data_ready,
	output logic tbre,
	output logic tsre
);

	import mem_pkg::*;

	logic [WORD_W-1:0] sram [2**ADDR_W];
	logic [BYTE_W-1:0] rx_buf [64];
	logic [BYTE_W-1:0] tx_log [16];
	int rx_head = 0;
	int rx_tail = 0;
	int tx_count;
	int tx_wait;
	int tbre_delay = 3;
	int tsre_delay = 3;

	task automatic deliver(input logic [BYTE_W-1:0] b);
		rx_buf[rx_head[5:0]] = b;
		rx_head++;
	endtask

	assign data_ready = (rx_head != rx_tail);

	// UART byte sits on the low lane
	always_comb begin
		if (!rdn) begin
			ram_din = {{(WORD_W - BYTE_W){1'b0}}, rx_buf[rx_tail[5:0]]};
		end else if (!ram_en && !ram_oe) begin
			ram_din = sram[ram_addr];
		end else begin
			ram_din = '0;
		end
	end

	always @(posedge clk) begin
		if (!ram_en && !ram_we && ram_doe) begin
			sram[ram_addr] <= ram_dout;
		end
	end

	// Byte leaves the chip at the end of the read strobe
	always @(posedge rdn) begin
		if (rx_tail != rx_head) begin
			rx_tail <= rx_tail + 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Transmit side
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			tbre <= 1'b1;
			tsre <= 1'b1;
			tx_count <= 0;
			tx_wait <= 0;
		end else if (!wrn) begin
			tx_log[tx_count[3:0]] <= ram_dout[BYTE_W-1:0];
			tx_count <= tx_count + 1;
			tbre <= 1'b0;
			tsre <= 1'b0;
			tx_wait <= tbre_delay;
		end else if (!tbre) begin
			if (tx_wait == 0) begin
				tbre <= 1'b1;
				tx_wait <= tsre_delay;
			end else begin
				tx_wait <= tx_wait - 1;
			end
		end else if (!tsre) begin
			if (tx_wait == 0) begin
				tsre <= 1'b1;
			end else begin
				tx_wait <= tx_wait - 1;
			end
		end
	end

endmodule

// File: mem_uart_checker.sv
`timescale 1ns/1ns

module mem_uart_checker (
	input logic clk,
	input logic rst,
	input logic ram_oe,
	input logic ram_we,
	input logic ram_doe,
	input logic rdn,
	input logic wrn,
	input logic rsp_valid
);

	a_oe_we: assert property (@(posedge clk) disable iff (!rst) !(!ram_oe && !ram_we))
		else $error("ram_oe and ram_we low together");

	a_rdn_wrn: assert property (@(posedge clk) disable iff (!rst) !(!rdn && !wrn))
		else $error("rdn and wrn low together");

	// Bus contention with the SRAM output
	a_doe_oe: assert property (@(posedge clk) disable iff (!rst) !(ram_doe && !ram_oe))
		else $error("ram_doe high while ram_oe low");

	a_rsp_pulse: assert property (@(posedge clk) disable iff (!rst) rsp_valid |=> !rsp_valid)
		else $error("rsp_valid high for two cycles");

endmodule

bind bus_sequencer mem_uart_checker u_checker (
	.clk(clk),
	.rst(rst),
	.ram_oe(ram_oe),
	.ram_we(ram_we),
	.ram_doe(ram_doe),
	.rdn(rdn),
	.wrn(wrn),
	.rsp_valid(rsp_valid)
);

// File: tb_mem_uart.sv
`timescale 1ns/1ns

module tb_mem_uart;

	import mem_pkg::*;

	localparam int CLK_PERIOD = 8;
	// Cycle budget of reset and the six tests
	localparam int TEST_CYCLES = 8 + 120 + 60 + 200 + 80 + 120 + 40;
	localparam int REQ_TIMEOUT = 300;

	logic clk;
	logic rst;
	logic req_valid;
	mem_req_t req;
	logic rsp_valid;
	mem_rsp_t rsp;
	logic [ADDR_W-1:0] ram_addr;
	logic [WORD_W-1:0] ram_dout;
	logic [WORD_W-1:0] ram_din;
	logic ram_doe, ram_en, ram_oe, ram_we;
	logic rdn, wrn, data_ready, tbre, tsre;
	logic saw_tsre_rise;
	int seed = 67968;

	mem_uart_top dut (.*);

	tb_dev_models models (.*);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	initial begin
		#((TEST_CYCLES + 400) * CLK_PERIOD);
		fail_run("Watchdog expired before the tests finished");
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			fail_run($sformatf("[ERROR] %0t ns: %s: got %0h, expected %0h", $time, what, got, exp));
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// One strobe, then count cycles up to the response
	task automatic do_request(input mem_op_t op, input logic [ADDR_W-1:0] addr,
			input logic [WORD_W-1:0] wdata, output logic [WORD_W-1:0] rdata,
			output int cycles);
		logic tsre_low;
		tsre_low = 1'b0;
		saw_tsre_rise = 1'b0;
		cycles = 0;
		req = '{op, addr, wdata};
		req_valid = 1'b1;
		do begin
			@(posedge clk);
			#1;
			req_valid = 1'b0;
			cycles++;
			if (!tsre) begin
				tsre_low = 1'b1;
			end else if (tsre_low) begin
				saw_tsre_rise = 1'b1;
			end
			if (cycles > REQ_TIMEOUT) fail_run("No response to a request within the time limit");
		end while (!rsp_valid);
		rdata = rsp.rdata;
	endtask

	task automatic wait_rx_count(input int target);
		int n = 0;
		while (models.rx_tail != target) begin
			wait_cycles(1);
			n++;
			if (n > 200) fail_run("The DUT did not read the UART bytes in time");
		end
	endtask

	task automatic wait_tx_count(input int target);
		int n = 0;
		while (models.tx_count != target) begin
			wait_cycles(1);
			n++;
			if (n > 200) fail_run("The DUT did not write to the UART in time");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_ram_random();
		logic [ADDR_W-1:0] addr [10];
		logic [WORD_W-1:0] data [10];
		logic [WORD_W-1:0] rdata;
		int order [10];
		int j, tmp, cycles;
		check_eq(32'({ram_en, ram_oe, ram_we, rdn, wrn, ram_doe, rsp_valid}), 32'b111_1100,
			"bus lines after reset");
		for (int i = 0; i < 10; i++) begin
			// Low nibble keeps the addresses apart
			addr[i] = {12'($random(seed)), 4'(i)};
			if (addr[i][15:4] == 12'hBF0) addr[i][15] = 1'b0;
			data[i] = 16'($random(seed));
			order[i] = i;
			do_request(MEM_WRITE, addr[i], data[i], rdata, cycles);
			check_eq(cycles, 4, "RAM write latency");
		end
		for (int i = 9; i > 0; i--) begin
			j = $unsigned($random(seed)) % (i + 1);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < 10; i++) begin
			do_request(MEM_READ, addr[order[i]], '0, rdata, cycles);
			check_eq(32'(rdata), 32'(data[order[i]]), "RAM read data");
			check_eq(cycles, 4, "RAM read latency");
		end
	endtask

	task automatic test_uart_receive();
		logic [BYTE_W-1:0] bytes [3];
		logic [WORD_W-1:0] rdata;
		int base, cycles;
		base = models.rx_tail;
		for (int i = 0; i < 3; i++) begin
			bytes[i] = 8'($random(seed));
			models.deliver(bytes[i]);
		end
		wait_rx_count(base + 3);
		wait_cycles(2);
		do_request(MEM_READ, UART_STAT_ADDR, '0, rdata, cycles);
		check_eq(32'(rdata), 32'h1, "status with bytes queued");
		check_eq(cycles, 2, "status read latency");
		for (int i = 0; i < 3; i++) begin
			do_request(MEM_READ, UART_DATA_ADDR, '0, rdata, cycles);
			check_eq(32'(rdata), 32'(bytes[i]), "received byte");
			check_eq(cycles, 3, "data read latency");
		end
		do_request(MEM_READ, UART_STAT_ADDR, '0, rdata, cycles);
		check_eq(32'(rdata), 32'h0, "status with empty queue");
		do_request(MEM_READ, UART_DATA_ADDR, '0, rdata, cycles);
		check_eq(32'(rdata), 32'h0, "data read from empty queue");
	endtask

	task automatic test_queue_full();
		logic [BYTE_W-1:0] bytes [17];
		logic [WORD_W-1:0] rdata;
		int base, cycles;
		base = models.rx_tail;
		for (int i = 0; i < 17; i++) begin
			bytes[i] = 8'($random(seed));
			models.deliver(bytes[i]);
		end
		wait_rx_count(base + 16);
		wait_cycles(6);
		check_eq(models.rx_tail - base, 16, "bytes taken with a full queue");
		check_eq(32'(data_ready), 32'h1, "last byte still pending");
		do_request(MEM_READ, UART_STAT_ADDR, '0, rdata, cycles);
		check_eq(32'(rdata), 32'h3, "status with full queue");
		do_request(MEM_READ, UART_DATA_ADDR, '0, rdata, cycles);
		check_eq(32'(rdata), 32'(bytes[0]), "first byte of full queue");
		wait_rx_count(base + 17);
		for (int i = 1; i < 17; i++) begin
			do_request(MEM_READ, UART_DATA_ADDR, '0, rdata, cycles);
			check_eq(32'(rdata), 32'(bytes[i]), "byte order after full queue");
		end
		do_request(MEM_READ, UART_STAT_ADDR, '0, rdata, cycles);
		check_eq(32'(rdata), 32'h0, "status after draining");
	endtask

	task automatic test_uart_write();
		logic [WORD_W-1:0] word;
		logic [WORD_W-1:0] rdata;
		int base, cycles;
		models.tbre_delay = 3;
		models.tsre_delay = 4;
		base = models.tx_count;
		for (int i = 0; i < 3; i++) begin
			word = 16'($random(seed));
			do_request(MEM_WRITE, UART_DATA_ADDR, word, rdata, cycles);
			check_eq(32'(saw_tsre_rise), 32'h1, "write response only after tsre");
			check_eq(32'(models.tx_log[4'(base + i)]), 32'(word[7:0]), "byte sent to UART");
		end
		check_eq(models.tx_count - base, 3, "number of UART writes");
	endtask

	task automatic test_write_retry();
		logic [WORD_W-1:0] word;
		logic [WORD_W-1:0] rdata;
		int base, cycles;
		models.tbre_delay = TX_TIMEOUT + 20;
		base = models.tx_count;
		word = 16'($random(seed));
		fork
			begin
				do_request(MEM_WRITE, UART_DATA_ADDR, word, rdata, cycles);
			end
			begin
				// Retry gets a fast transmitter
				wait_tx_count(base + 1);
				models.tbre_delay = 2;
			end
		join
		check_eq(models.tx_count - base, 2, "byte written again after timeout");
		check_eq(32'(models.tx_log[4'(base)]), 32'(word[7:0]), "first attempt byte");
		check_eq(32'(models.tx_log[4'(base + 1)]), 32'(word[7:0]), "retried byte");
		check_eq(32'(cycles > TX_TIMEOUT), 32'h1, "retry waited past the timeout");
		check_eq(32'(saw_tsre_rise), 32'h1, "retry response after tsre");
	endtask

	task automatic test_read_during_rx();
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] word;
		logic [WORD_W-1:0] rdata;
		logic [BYTE_W-1:0] b;
		int base, cycles;
		int n = 0;
		addr = 16'h0A5C;
		word = 16'($random(seed));
		b = 8'($random(seed));
		do_request(MEM_WRITE, addr, word, rdata, cycles);
		base = models.rx_tail;
		models.deliver(b);
		while (rdn) begin
			wait_cycles(1);
			n++;
			if (n > 20) fail_run("The DUT never started reading the UART byte");
		end
		do_request(MEM_READ, addr, '0, rdata, cycles);
		check_eq(32'(rdata), 32'(word), "RAM read during receive");
		check_eq(models.rx_tail - base, 1, "byte taken during the read");
		do_request(MEM_READ, UART_STAT_ADDR, '0, rdata, cycles);
		check_eq(32'(rdata), 32'h1, "status after receive");
		do_request(MEM_READ, UART_DATA_ADDR, '0, rdata, cycles);
		check_eq(32'(rdata), 32'(b), "byte queued during the read");
	endtask

	initial begin
		rst = 1'b0;
		req_valid = 1'b0;
		req = '0;
		saw_tsre_rise = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b1;
		wait_cycles(1);
		test_ram_random();
		test_uart_receive();
		test_queue_full();
		test_uart_write();
		test_write_retry();
		test_read_during_rx();
		wait_cycles(4);
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: src.f
mem_pkg.sv
mem_req_decode.sv
rx_queue.sv
bus_sequencer.sv
mem_uart_top.sv
tb_dev_models.sv
mem_uart_checker.sv
tb_mem_uart.sv

// File: sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
	--top-module tb_mem_uart \
	-f src.f \
	-o tb_mem_uart
./obj_dir/tb_mem_uart
